// File: list.f
rtl/spdif_pkg.sv
rtl/byte_fifo.sv
rtl/sample_assembler.sv
rtl/biphase_encoder.sv
rtl/spdif_tx.sv
verification/spdif_checker.sv
verification/tb_spdif_tx.sv

// File: Makefile
# Verilator build and run for the S/PDIF transmitter testbench.
VERILATOR ?= verilator
TOP       ?= tb_spdif_tx
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_spdif_tx.sv
// Testbench top for the S/PDIF transmitter.
// Writes seeded random audio in whole frames through three streams
// (24-bit over a full block, then 16-bit, then 24-bit again), waits for
// each stream to drain, and prints the closing report.
`timescale 1ns/1ps

module tb_spdif_tx
    import spdif_pkg::*;
();

    localparam int FIFO_ADDR_W  = 4;
    localparam int FRAMES_LONG  = 210;
    localparam int FRAMES_SHORT = 40;
    localparam int FRAMES_LAST  = 20;
    // Each written frame takes 128 cycles on the line, plus slack.
    localparam int CYCLE_LIMIT  = 140 * (FRAMES_LONG + FRAMES_SHORT + FRAMES_LAST) + 2000;

    logic       byte_clk;
    logic       reset;
    bit_depth_e bit_depth;
    logic       wr_en;
    byte_t      wr_data;
    logic       full;
    logic       almost_full;
    logic       streaming;
    logic       spdif;
    integer     seed;
    int         cycles = 0;
    int         errors;
    int         pending;
    int         decoded;
    logic       line_idle;

    initial begin
        byte_clk = 1'b0;
        forever #50 byte_clk = ~byte_clk;
    end

    spdif_tx #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) uut (
        .byte_clk_i    (byte_clk),
        .reset_i       (reset),
        .bit_depth_i   (bit_depth),
        .wr_en_i       (wr_en),
        .wr_data_i     (wr_data),
        .full_o        (full),
        .almost_full_o (almost_full),
        .streaming_o   (streaming),
        .spdif_o       (spdif)
    );

    spdif_checker #(
        .DEPTH (1 << FIFO_ADDR_W)
    ) line_check (
        .byte_clk_i      (byte_clk),
        .reset_i         (reset),
        .bit_depth_i     (bit_depth),
        .wr_en_i         (wr_en),
        .wr_data_i       (wr_data),
        .full_i          (full),
        .almost_full_i   (almost_full),
        .streaming_i     (streaming),
        .spdif_i         (spdif),
        .error_count_o   (errors),
        .pending_o       (pending),
        .decoded_o       (decoded),
        .line_idle_o     (line_idle)
    );

    // The run may not outlast the worst case for the frames written.
    always @(posedge byte_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the line did not drain within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // One byte is written every other cycle, and only while the FIFO has room.
    task automatic write_byte();
        @(posedge byte_clk);
        while (full) begin
            @(posedge byte_clk);
        end
        wr_en   <= 1'b1;
        wr_data <= byte_t'($random(seed));
        @(posedge byte_clk);
        wr_en   <= 1'b0;
    endtask

    // Sends a number of frames in random bursts with random idle gaps.
    task automatic send_stream(input bit_depth_e depth, input int frames);
        int sent;
        int burst;
        int gap;
        sent = 0;
        @(posedge byte_clk);
        bit_depth <= depth;
        while (sent < frames) begin
            burst = 1 + ($unsigned($random(seed)) % 4);
            for (int j = 0; j < burst && sent < frames; j++) begin
                repeat ((depth == DEPTH_24) ? 6 : 4) write_byte();
                sent++;
            end
            gap = $unsigned($random(seed)) % 16;
            repeat (gap) @(posedge byte_clk);
        end
    endtask

    // Waits until every sample went out and the stream has ended.
    task automatic wait_drain();
        @(posedge byte_clk);
        while (pending != 0 || !line_idle || streaming) begin
            @(posedge byte_clk);
        end
        repeat (20) @(posedge byte_clk);
    endtask

    initial begin
        seed      = 32'h4cf668ac;
        reset     = 1'b1;
        wr_en     = 1'b0;
        wr_data   = '0;
        bit_depth = DEPTH_24;
        repeat (2) @(posedge byte_clk);
        reset <= 1'b0;
        send_stream(DEPTH_24, FRAMES_LONG);
        wait_drain();
        send_stream(DEPTH_16, FRAMES_SHORT);
        wait_drain();
        send_stream(DEPTH_24, FRAMES_LAST);
        wait_drain();
        $display("report: %0d subframes decoded, %0d errors", decoded, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verification/spdif_checker.sv
// Line checker for the S/PDIF transmitter testbench.
// Models the expected samples from the FIFO writes, decodes spdif_o one
// half-cell per cycle and compares preamble, slots and parity. It also
// checks the FIFO flags against the byte count still in flight.
`timescale 1ns/1ps

module spdif_checker
    import spdif_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic       byte_clk_i,
    input  logic       reset_i,
    input  bit_depth_e bit_depth_i,
    input  logic       wr_en_i,
    input  byte_t      wr_data_i,
    input  logic       full_i,
    input  logic       almost_full_i,
    input  logic       streaming_i,
    input  logic       spdif_i,
    output int         error_count_o,
    output int         pending_o,
    output int         decoded_o,
    output logic       line_idle_o
);

    // At most one word is on the line and one waits for it, 3 bytes each at 24 bits.
    localparam int IN_FLIGHT_MAX = 2 * 3;

    audio_t      exp_q[$];
    int          nb_q[$];
    audio_t      acc;
    int          byte_cnt;
    int          wr_bytes;
    int          rd_bytes;
    logic        prev_lvl;
    logic        lvl_before;
    logic        active;
    logic        right_exp;
    int          hcn;
    int          frame_in_block;
    logic [63:0] hcs;

    assign pending_o   = exp_q.size();
    assign line_idle_o = !active;

    // Decodes the 64 captured half-cells and compares them with the model.
    task automatic check_subframe();
        preamble_t   pre;
        preamble_t   want;
        logic [27:0] cells;
        audio_t      exp;
        for (int i = 0; i < 8; i++) begin
            pre[7-i] = hcs[i];
        end
        want = right_exp ? PREAMBLE_W : ((frame_in_block == 0) ? PREAMBLE_B : PREAMBLE_M);
        if (!lvl_before) begin
            want = ~want;
        end
        if (pre != want) begin
            $display("mismatch at %0t: preamble %b, expected %b", $time, pre, want);
            error_count_o++;
        end
        for (int k = 0; k < 28; k++) begin
            // Each cell must open with a transition.
            if (hcs[8+2*k] == hcs[7+2*k]) begin
                $display("mismatch at %0t: no transition at start of slot %0d", $time, k + 4);
                error_count_o++;
            end
            cells[k] = hcs[8+2*k] ^ hcs[9+2*k];
        end
        if (cells[26:24] != 3'b000 || ^cells != 1'b0) begin
            $display("mismatch at %0t: VUC %b or parity wrong in slots %h", $time,
                     cells[26:24], cells);
            error_count_o++;
        end
        if (exp_q.size() == 0) begin
            $display("mismatch at %0t: subframe %h sent with no sample written", $time,
                     cells[23:0]);
            error_count_o++;
        end else begin
            exp = exp_q.pop_front();
            rd_bytes += nb_q.pop_front();
            if (cells[23:0] != exp) begin
                $display("mismatch at %0t: audio %h, expected %h", $time, cells[23:0], exp);
                error_count_o++;
            end
        end
        // The stream lasts while written samples still wait for the line.
        if (exp_q.size() != 0 && !streaming_i) begin
            $display("mismatch at %0t: streaming_o low with %0d samples queued", $time,
                     exp_q.size());
            error_count_o++;
        end
        decoded_o++;
        if (right_exp) begin
            frame_in_block = (frame_in_block + 1) % FRAMES_PER_BLOCK;
        end
        right_exp = !right_exp;
    endtask

    // Sampling on the falling edge sees each half-cell and each flag settled.
    always @(negedge byte_clk_i) begin
        if (reset_i) begin
            error_count_o = 0;
            decoded_o     = 0;
            byte_cnt      = 0;
            acc           = '0;
            wr_bytes      = 0;
            rd_bytes      = 0;
            prev_lvl      = 1'b1;
            active        = 1'b0;
            hcn           = 0;
            hcs           = '0;
        end else begin
            // Bytes written but not yet decoded bound the fill from above, and
            // exceed it by at most the words between the FIFO and the line.
            if (full_i && wr_bytes - rd_bytes < DEPTH) begin
                $display("mismatch at %0t: full_o high with %0d bytes outstanding", $time,
                         wr_bytes - rd_bytes);
                error_count_o++;
            end
            if (!full_i && wr_bytes - rd_bytes - IN_FLIGHT_MAX >= DEPTH) begin
                $display("mismatch at %0t: full_o low with %0d bytes outstanding", $time,
                         wr_bytes - rd_bytes);
                error_count_o++;
            end
            if (almost_full_i && wr_bytes - rd_bytes < DEPTH - 4) begin
                $display("mismatch at %0t: almost_full_o high with %0d bytes outstanding",
                         $time, wr_bytes - rd_bytes);
                error_count_o++;
            end
            if (!almost_full_i && wr_bytes - rd_bytes - IN_FLIGHT_MAX >= DEPTH - 4) begin
                $display("mismatch at %0t: almost_full_o low with %0d bytes outstanding",
                         $time, wr_bytes - rd_bytes);
                error_count_o++;
            end
            if (wr_en_i && full_i) begin
                $display("the writer wrote while the FIFO was full at %0t", $time);
                error_count_o++;
            end else if (wr_en_i) begin
                // 16-bit samples are placed MSB aligned, one byte up.
                acc |= audio_t'(wr_data_i) << (8 * (byte_cnt +
                        ((bit_depth_i == DEPTH_16) ? 1 : 0)));
                byte_cnt++;
                wr_bytes++;
                if (byte_cnt == ((bit_depth_i == DEPTH_24) ? 3 : 2)) begin
                    exp_q.push_back(acc);
                    nb_q.push_back(byte_cnt);
                    acc      = '0;
                    byte_cnt = 0;
                end
            end

            // Line decoding.
            if (!active || hcn == 63) begin
                if (spdif_i != prev_lvl) begin
                    if (!active) begin
                        frame_in_block = 0;
                        right_exp      = 1'b0;
                        if (!streaming_i) begin
                            $display("the line started while streaming_o was low at %0t",
                                     $time);
                            error_count_o++;
                        end
                    end
                    active     = 1'b1;
                    hcn        = 0;
                    lvl_before = prev_lvl;
                    hcs[0]     = spdif_i;
                end else if (active) begin
                    active = 1'b0;
                    if (right_exp) begin
                        $display("the line stopped after a left subframe at %0t", $time);
                        error_count_o++;
                    end
                    if (exp_q.size() != 0) begin
                        $display("the line went idle with %0d samples still queued at %0t",
                                 exp_q.size(), $time);
                        error_count_o++;
                    end
                    if (exp_q.size() == 0 && streaming_i) begin
                        $display("streaming_o stayed high after the stream ended at %0t",
                                 $time);
                        error_count_o++;
                    end
                end
            end else begin
                hcn++;
                hcs[hcn] = spdif_i;
                if (hcn == 63) begin
                    check_subframe();
                end
            end
            prev_lvl = spdif_i;
        end
    end

endmodule

// File: rtl/spdif_tx.sv
// Top level of the S/PDIF transmitter.
// Audio bytes written here pass through the byte FIFO to the sample
// assembler, which feeds the biphase encoder driving spdif_o.
// The writer must hold off while full_o is high.
`timescale 1ns/1ps

module spdif_tx
    import spdif_pkg::*;
#(
    parameter int FIFO_ADDR_W = 4
) (
    input  logic       byte_clk_i,
    input  logic       reset_i,
    input  bit_depth_e bit_depth_i,
    input  logic       wr_en_i,
    input  byte_t      wr_data_i,
    output logic       full_o,
    output logic       almost_full_o,
    output logic       streaming_o,
    output logic       spdif_o
);

    // FIFO read side.
    logic         rd_en;
    byte_t        rd_data;
    logic         empty;

    // Assembler to encoder handshake.
    sample_word_t word;
    logic         req;
    logic         ack;

    byte_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_fifo (
        .byte_clk_i    (byte_clk_i),
        .reset_i       (reset_i),
        .wr_en_i       (wr_en_i),
        .wr_data_i     (wr_data_i),
        .rd_en_i       (rd_en),
        .rd_data_o     (rd_data),
        .empty_o       (empty),
        .full_o        (full_o),
        .almost_full_o (almost_full_o)
    );

    sample_assembler u_assembler (
        .byte_clk_i   (byte_clk_i),
        .reset_i      (reset_i),
        .bit_depth_i  (bit_depth_i),
        .fifo_data_i  (rd_data),
        .fifo_empty_i (empty),
        .fifo_rd_en_o (rd_en),
        .word_o       (word),
        .req_o        (req),
        .ack_i        (ack),
        .streaming_o  (streaming_o)
    );

    biphase_encoder u_encoder (
        .byte_clk_i (byte_clk_i),
        .reset_i    (reset_i),
        .word_i     (word),
        .req_i      (req),
        .ack_o      (ack),
        .spdif_o    (spdif_o)
    );

endmodule

// File: rtl/biphase_encoder.sv
// Biphase-mark encoder of the S/PDIF transmitter.
// Takes one sample word per subframe over req/ack and sends it as 64
// half-cells, one per clock: an 8 half-cell preamble, 24 audio bits LSB
// first, then V, U, C and P. Frames are counted to place B every 192.
`timescale 1ns/1ps

module biphase_encoder
    import spdif_pkg::*;
(
    input  logic         byte_clk_i,
    input  logic         reset_i,
    input  sample_word_t word_i,
    input  logic         req_i,
    output logic         ack_o,
    output logic         spdif_o
);

    localparam int PREAMBLE_HALF_CELLS = 8;
    localparam int CONTROL_FIRST_HC    = HALF_CELLS_PER_SUBFRAME - 8;
    localparam int SLOT_CELLS          = 28;
    localparam logic [5:0] LAST_HC     = 6'(HALF_CELLS_PER_SUBFRAME - 1);
    localparam logic [7:0] LAST_FRAME  = 8'(FRAMES_PER_BLOCK - 1);

    enc_state_e            state;
    logic [5:0]            hc;          // Half-cell now on the line.
    logic [5:0]            hc_next;
    logic [7:0]            frame_cnt;
    logic                  pending;     // A latched word waits to be sent.
    sample_word_t          next_word;
    preamble_t             pattern;
    preamble_t             pre_sr;
    logic [SLOT_CELLS-1:0] data_sr;
    logic                  frame_end;
    logic                  start;
    logic                  accept;

    assign hc_next   = hc + 6'd1;
    assign frame_end = (state == ST_IDLE) || (state == ST_CONTROL && hc == LAST_HC);
    assign start     = frame_end && pending;

    // Words are taken when idle or during the 64th half-cell, so the ack
    // rises exactly one cycle before the first preamble half-cell.
    assign accept = req_i && !ack_o && !pending &&
                    (state == ST_IDLE || (state == ST_CONTROL && hc == LAST_HC - 6'd1));

    // Preamble selection by channel and block position.
    always_comb begin
        if (next_word.right_channel) begin
            pattern = PREAMBLE_W;
        end else if (frame_cnt == '0) begin
            pattern = PREAMBLE_B;
        end else begin
            pattern = PREAMBLE_M;
        end
        // The constants assume a high line; invert them after a low one.
        if (!spdif_o) begin
            pattern = ~pattern;
        end
    end

    // ==================================================
    // Handshake
    // ==================================================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else if (accept) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    // ==================================================
    // Line FSM
    // ==================================================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            hc        <= '0;
            frame_cnt <= '0;
            pending   <= 1'b0;
            spdif_o   <= 1'b1;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end else if (start) begin
                pending <= 1'b0;
            end
            if (start) begin
                state   <= ST_PREAMBLE;
                hc      <= '0;
                spdif_o <= pattern[7];
                // A frame is complete once its right subframe begins.
                if (next_word.right_channel) begin
                    frame_cnt <= (frame_cnt == LAST_FRAME) ? '0 : frame_cnt + 8'd1;
                end
            end else if (frame_end) begin
                // Nothing to send, so hold the line and restart the block.
                state     <= ST_IDLE;
                frame_cnt <= '0;
            end else begin
                hc <= hc_next;
                if (hc_next < 6'(PREAMBLE_HALF_CELLS)) begin
                    state   <= ST_PREAMBLE;
                    spdif_o <= pre_sr[7];
                end else begin
                    state <= (hc_next < 6'(CONTROL_FIRST_HC)) ? ST_DATA : ST_CONTROL;
                    // Every cell opens with a transition; a 1 adds one mid-cell.
                    if (!hc_next[0] || data_sr[0]) begin
                        spdif_o <= !spdif_o;
                    end
                end
            end
        end
    end

    // Shift registers for the preamble and the slot bits.
    always_ff @(posedge byte_clk_i) begin
        if (accept) begin
            next_word <= word_i;
        end
        if (start) begin
            pre_sr  <= {pattern[6:0], 1'b0};
            data_sr <= {next_word.parity, 3'b000, next_word.audio};
        end else if (!frame_end) begin
            if (hc_next < 6'(PREAMBLE_HALF_CELLS)) begin
                pre_sr <= pre_sr << 1;
            end else if (hc_next[0]) begin
                data_sr <= data_sr >> 1;
            end
        end
    end

endmodule

// File: rtl/sample_assembler.sv
// Sample assembler of the S/PDIF transmitter.
// Reads 2 or 3 bytes per sample from the FIFO, first byte least
// significant, builds the channel word with even parity and offers it
// to the encoder over a four-phase req/ack handshake. It also decides
// when a stream begins and ends.
`timescale 1ns/1ps

module sample_assembler
    import spdif_pkg::*;
(
    input  logic         byte_clk_i,
    input  logic         reset_i,
    input  bit_depth_e   bit_depth_i,
    input  byte_t        fifo_data_i,
    input  logic         fifo_empty_i,
    output logic         fifo_rd_en_o,
    output sample_word_t word_o,
    output logic         req_o,
    input  logic         ack_i,
    output logic         streaming_o
);

    // Collect bytes, hold req until ack, then wait for ack to drop.
    typedef enum logic [1:0] {
        AS_COLLECT,
        AS_REQ,
        AS_RELEASE
    } asm_state_e;

    asm_state_e phase;
    logic [1:0] rd_cnt;      // Reads issued for the current sample.
    logic [1:0] cap_cnt;     // Bytes captured for the current sample.
    logic [1:0] n_bytes;
    logic [1:0] byte_sel;
    logic       rd_valid;
    logic       right_channel;
    logic       last_byte;
    audio_t     placed;

    assign n_bytes = (bit_depth_i == DEPTH_24) ? 2'd3 : 2'd2;

    // Only read while collecting and while the sample still lacks bytes.
    assign fifo_rd_en_o = (phase == AS_COLLECT) && (rd_cnt != n_bytes) && !fifo_empty_i;

    // 16-bit samples are MSB aligned, so their first byte lands in bits 8 to 15.
    assign byte_sel  = (bit_depth_i == DEPTH_16) ? cap_cnt + 2'd1 : cap_cnt;
    assign placed    = audio_t'(fifo_data_i) << {byte_sel, 3'b000};
    assign last_byte = rd_valid && (cap_cnt == n_bytes - 2'd1);

    // ==================================================
    // Control and handshake
    // ==================================================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            phase         <= AS_COLLECT;
            rd_cnt        <= '0;
            cap_cnt       <= '0;
            rd_valid      <= 1'b0;
            req_o         <= 1'b0;
            right_channel <= 1'b0;
            streaming_o   <= 1'b0;
        end else begin
            // The FIFO output is valid one cycle after the read.
            rd_valid <= fifo_rd_en_o;
            if (fifo_rd_en_o) begin
                rd_cnt      <= rd_cnt + 2'd1;
                streaming_o <= 1'b1;
            end
            case (phase)
                AS_COLLECT: begin
                    if (last_byte) begin
                        rd_cnt  <= '0;
                        cap_cnt <= '0;
                        req_o   <= 1'b1;
                        phase   <= AS_REQ;
                    end else if (rd_valid) begin
                        cap_cnt <= cap_cnt + 2'd1;
                    end
                end
                AS_REQ: begin
                    // The encoder has latched the word.
                    if (ack_i) begin
                        req_o <= 1'b0;
                        phase <= AS_RELEASE;
                    end
                end
                default: begin
                    if (!ack_i) begin
                        phase         <= AS_COLLECT;
                        right_channel <= !right_channel;
                        // A drained FIFO after a full frame ends the stream.
                        if (right_channel && fifo_empty_i) begin
                            streaming_o <= 1'b0;
                        end
                    end
                end
            endcase
        end
    end

    // ==================================================
    // Word building
    // ==================================================
    // Word_o only changes while collecting, so it is stable under req.
    always_ff @(posedge byte_clk_i) begin
        if (rd_valid && phase == AS_COLLECT) begin
            if (cap_cnt == 2'd0) begin
                word_o.right_channel <= right_channel;
                word_o.audio         <= placed;
                word_o.parity        <= ^fifo_data_i;
            end else begin
                word_o.audio  <= word_o.audio | placed;
                word_o.parity <= word_o.parity ^ (^fifo_data_i);
            end
        end
    end

endmodule

// File: rtl/byte_fifo.sv
// Synchronous byte FIFO between the audio writer and the sample assembler.
// Writes are dropped while full; reads return data one cycle after the
// read is taken. Full and almost-full come from the pointer difference.
`timescale 1ns/1ps

module byte_fifo
    import spdif_pkg::*;
#(
    parameter int FIFO_ADDR_W = 4
) (
    input  logic  byte_clk_i,
    input  logic  reset_i,
    input  logic  wr_en_i,
    input  byte_t wr_data_i,
    input  logic  rd_en_i,
    output byte_t rd_data_o,
    output logic  empty_o,
    output logic  full_o,
    output logic  almost_full_o
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;
    // Fill levels in pointer width; almost-full fires 4 entries early.
    localparam logic [FIFO_ADDR_W:0] FULL_LEVEL = {1'b1, {FIFO_ADDR_W{1'b0}}};
    localparam logic [FIFO_ADDR_W:0] AF_MARGIN  = 4;

    byte_t mem [DEPTH];

    // Pointers carry one extra bit to tell full from empty.
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic [FIFO_ADDR_W:0] fill;
    logic                 do_write;
    logic                 do_read;

    assign fill          = wr_ptr - rd_ptr;
    assign empty_o       = (fill == '0);
    assign full_o        = (fill == FULL_LEVEL);
    assign almost_full_o = (fill >= FULL_LEVEL - AF_MARGIN);

    assign do_write = wr_en_i && !full_o;
    assign do_read  = rd_en_i && !empty_o;

    // Pointer update.
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage and the registered read port.
    always_ff @(posedge byte_clk_i) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= wr_data_i;
        end
        if (do_read) begin
            rd_data_o <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end
    end

endmodule

// File: rtl/spdif_pkg.sv
// Shared types and constants for the S/PDIF transmitter.
// The FIFO, the sample assembler, the biphase encoder and the checker
// import this package with a wildcard import in their module headers.
package spdif_pkg;

    // ==================================================
    // Data widths
    // ==================================================
    // One audio byte as it leaves the FIFO.
    typedef logic [7:0] byte_t;

    // One sample in the 24-bit audio field, time slots 4 to 27.
    typedef logic [23:0] audio_t;

    // A preamble as 8 half-cells, sent bit 7 first.
    typedef logic [7:0] preamble_t;

    // The word handed from the assembler to the encoder.
    // V, U and C are all zero, so parity covers the audio bits only.
    typedef struct packed {
        logic   right_channel;
        audio_t audio;
        logic   parity;
    } sample_word_t;

    // Sample depth as selected by the host.
    typedef enum logic {
        DEPTH_16 = 1'b0,
        DEPTH_24 = 1'b1
    } bit_depth_e;

    // Encoder FSM states.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_CONTROL
    } enc_state_e;

    // ==================================================
    // Framing constants
    // ==================================================
    // Patterns for a previous line level of 1; a level of 0 uses the inverse.
    localparam preamble_t PREAMBLE_B = 8'b00010111;
    localparam preamble_t PREAMBLE_M = 8'b00011101;
    localparam preamble_t PREAMBLE_W = 8'b00011011;

    localparam int FRAMES_PER_BLOCK        = 192;
    localparam int HALF_CELLS_PER_SUBFRAME = 64;

endpackage
